// ==== compile.f ====
jbi_pkg.sv
jbi_req_fifo.sv
jbi_aok_dok_tracker.sv
jbi_flow_gate.sv
jbi_issue_reg.sv
jbi_status_log.sv
jbi_flow_top.sv
tb_jbi_flow.sv

// ==== jbi_aok_dok_tracker.sv ====
module jbi_aok_dok_tracker import jbi_pkg::*; (
  input  logic               clk,
  input  logic               arst_n,
  input  jpack_code_e        j_pack0_m1,
  input  jpack_code_e        j_pack1_m1,
  input  jpack_code_e        j_pack4_p1,
  input  jpack_code_e        j_pack5_p1,
  output jbi_permit_t        permit,
  output jbi_err_t           err,
  output logic               aok_off_any,
  output logic               dok_off_any,
  output logic [NUM_AID-1:0] log_arb_aok,
  output logic [NUM_AID-1:0] log_arb_dok
);

  // own codes, two stages to line up with the external devices
  jpack_code_e j_pack0, j_pack0_p1;
  jpack_code_e j_pack1, j_pack1_p1;

  // address tracking, index 0..3 maps to ports 0, 1, 4, 5
  jpack_code_e            aok_code [NUM_AOK_TRK];
  logic [NUM_AOK_TRK-1:0] set_aok, clr_aok, aok_off_q, aok_off;

  // data tracking, index 0..1 maps to ports 4, 5
  jpack_code_e            dok_code [NUM_DOK_TRK];
  logic [NUM_DOK_TRK-1:0] set_dok, clr_dok, dok_off_q, dok_off;
  logic [DOK_ON_CNT_W-1:0] dok_on_cnt [NUM_DOK_TRK];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      j_pack0    <= JP_IDLE;
      j_pack0_p1 <= JP_IDLE;
      j_pack1    <= JP_IDLE;
      j_pack1_p1 <= JP_IDLE;
    end else begin
      j_pack0    <= j_pack0_m1;
      j_pack0_p1 <= j_pack0;
      j_pack1    <= j_pack1_m1;
      j_pack1_p1 <= j_pack1;
    end
  end

  // decode set and clear per tracked port
  always_comb begin
    aok_code[0] = j_pack0_p1;
    aok_code[1] = j_pack1_p1;
    aok_code[2] = j_pack4_p1;
    aok_code[3] = j_pack5_p1;
    dok_code[0] = j_pack4_p1;
    dok_code[1] = j_pack5_p1;
    for (int i = 0; i < NUM_AOK_TRK; i++) begin
      set_aok[i] = (aok_code[i] == JP_AOK_OFF);
      clr_aok[i] = (aok_code[i] == JP_AOK_ON);
    end
    for (int i = 0; i < NUM_DOK_TRK; i++) begin
      set_dok[i] = (dok_code[i] == JP_DOK_OFF);
      clr_dok[i] = (dok_code[i] == JP_DOK_ON);
    end
  end

  // sticky off flags, set and clear never coincide
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      aok_off_q <= '0;
      dok_off_q <= '0;
    end else begin
      aok_off_q <= set_aok | (aok_off_q & ~clr_aok);
      dok_off_q <= set_dok | (dok_off_q & ~clr_dok);
    end
  end

  // current code acts in its own cycle, flag holds it afterwards
  assign aok_off = set_aok | (aok_off_q & ~clr_aok);
  assign dok_off = set_dok | (dok_off_q & ~clr_dok);

  // consecutive data-on counters, cleared by any other code
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_DOK_TRK; i++) begin
        dok_on_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_DOK_TRK; i++) begin
        if (dok_code[i] != JP_DOK_ON) begin
          dok_on_cnt[i] <= '0;
        end else if (dok_on_cnt[i] != '1) begin
          dok_on_cnt[i] <= dok_on_cnt[i] + 1'b1;
        end
      end
    end
  end

  // single pulse, count moves past the limit on the next data-on
  assign err.fatal_4 = (dok_on_cnt[0] == DOK_ON_CNT_W'(DOK_FATAL_COUNT));
  assign err.fatal_5 = (dok_on_cnt[1] == DOK_ON_CNT_W'(DOK_FATAL_COUNT));

  // any address-off blocks all address packets
  assign permit.ok_addr   = ~|aok_off;
  assign permit.ok_data_4 = ~dok_off[0];
  assign permit.ok_data_5 = ~dok_off[1];

  assign aok_off_any = |aok_off;
  assign dok_off_any = |dok_off;

  // 1 = on, untracked ports 2, 3, 6 always on
  assign log_arb_aok = ~{1'b0, aok_off[3], aok_off[2], 2'b00, aok_off[1], aok_off[0]};
  assign log_arb_dok = ~{1'b0, dok_off[1], dok_off[0], 4'b0000};

endmodule

// ==== jbi_flow_gate.sv ====
module jbi_flow_gate import jbi_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        in_valid,
  output logic        in_ready,
  input  jbi_req_t    in_req,
  input  jbi_permit_t permit,
  output logic        out_valid,
  input  logic        out_ready,
  output jbi_req_t    out_req
);

  // single held request
  logic     hold_valid;
  jbi_req_t hold_req;

  // permission for the held kind
  logic allowed;

  always_comb begin
    case (hold_req.kind)
      PK_DATA_4: allowed = permit.ok_data_4;
      PK_DATA_5: allowed = permit.ok_data_5;
      // address and unused kinds wait on address permission
      default:   allowed = permit.ok_addr;
    endcase
  end

  // released the first cycle permission is up
  assign out_valid = hold_valid && allowed;
  assign out_req   = hold_req;

  // refill in the same cycle the held request leaves
  assign in_ready = !hold_valid || (out_valid && out_ready);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hold_valid <= 1'b0;
    end else if (in_ready) begin
      hold_valid <= in_valid;
    end
  end

  // payload follows the valid bit
  always_ff @(posedge clk) begin
    if (in_ready && in_valid) begin
      hold_req <= in_req;
    end
  end

endmodule

// ==== jbi_flow_top.sv ====
module jbi_flow_top import jbi_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  jbi_req_t              in_req,
  output logic                  out_valid,
  input  logic                  out_ready,
  output jbi_req_t              out_req,
  input  jpack_code_e           j_pack0_m1,
  input  jpack_code_e           j_pack1_m1,
  input  jpack_code_e           j_pack4_p1,
  input  jpack_code_e           j_pack5_p1,
  input  logic [1:0]            err_clr,
  output logic [1:0]            fatal_err,
  output logic [PERF_CNT_W-1:0] perf_aok_off_cnt,
  output logic [PERF_CNT_W-1:0] perf_dok_off_cnt,
  output logic [NUM_AID-1:0]    log_arb_aok,
  output logic [NUM_AID-1:0]    log_arb_dok
);

  // queue to gate
  logic     fifo_valid, fifo_ready;
  jbi_req_t fifo_req;
  // gate to issue register
  logic     gate_valid, gate_ready;
  jbi_req_t gate_req;
  // tracker side outputs
  jbi_permit_t permit;
  jbi_err_t    err;
  logic        aok_off_any, dok_off_any;

  jbi_req_fifo jbi_req_fifo_inst (
    .clk, .arst_n, .in_valid, .in_ready, .in_req,
    .out_valid(fifo_valid), .out_ready(fifo_ready), .out_req(fifo_req)
  );

  // holds the head until flow control allows it
  jbi_flow_gate jbi_flow_gate_inst (
    .clk, .arst_n,
    .in_valid(fifo_valid), .in_ready(fifo_ready), .in_req(fifo_req), .permit,
    .out_valid(gate_valid), .out_ready(gate_ready), .out_req(gate_req)
  );

  jbi_issue_reg jbi_issue_reg_inst (
    .clk, .arst_n,
    .in_valid(gate_valid), .in_ready(gate_ready), .in_req(gate_req),
    .out_valid, .out_ready, .out_req
  );

  jbi_aok_dok_tracker jbi_aok_dok_tracker_inst (
    .clk, .arst_n, .j_pack0_m1, .j_pack1_m1, .j_pack4_p1, .j_pack5_p1,
    .permit, .err, .aok_off_any, .dok_off_any, .log_arb_aok, .log_arb_dok
  );

  jbi_status_log jbi_status_log_inst (
    .clk, .arst_n, .err, .aok_off_any, .dok_off_any, .err_clr,
    .fatal_err, .perf_aok_off_cnt, .perf_dok_off_cnt
  );

endmodule

// ==== jbi_issue_reg.sv ====
module jbi_issue_reg import jbi_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  jbi_req_t in_req,
  output logic     out_valid,
  input  logic     out_ready,
  output jbi_req_t out_req
);

  // main drives the bus side, skid catches one under back-pressure
  logic     main_valid, skid_valid;
  jbi_req_t main_req, skid_req;

  logic main_load;

  // ready comes straight from a flop
  assign in_ready  = !skid_valid;
  assign out_valid = main_valid;
  assign out_req   = main_req;

  // main slot empty or being taken this cycle
  assign main_load = !main_valid || out_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_load) begin
      // skid drains first to keep order
      main_valid <= skid_valid || in_valid;
      skid_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      // main stalled, park the new one
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_load) begin
      main_req <= skid_valid ? skid_req : in_req;
    end
    if (!skid_valid) begin
      skid_req <= in_req;
    end
  end

endmodule

// ==== jbi_pkg.sv ====
package jbi_pkg;

  // request queue sizing
  localparam int REQ_FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W     = $clog2(REQ_FIFO_DEPTH);
  localparam int FIFO_CNT_W     = $clog2(REQ_FIFO_DEPTH + 1);

  // packet payload width
  localparam int PAYLOAD_W = 16;

  // saturating off-cycle counters
  localparam int PERF_CNT_W = 16;

  // consecutive data-on counter, saturates at all ones
  localparam int DOK_ON_CNT_W    = 3;
  // counter value that flags a stuck data-on
  localparam int DOK_FATAL_COUNT = 4;

  // agent ids covered by the log vectors
  localparam int NUM_AID = 7;
  // address flags kept for ports 0, 1, 4, 5
  localparam int NUM_AOK_TRK = 4;
  // data flags kept for ports 4, 5
  localparam int NUM_DOK_TRK = 2;

  // j_pack status codes, unlisted encodings behave as idle
  typedef enum logic [2:0] {
    JP_IDLE    = 3'b000,
    JP_AOK_ON  = 3'b001,
    JP_AOK_OFF = 3'b010,
    JP_DOK_ON  = 3'b011,
    JP_DOK_OFF = 3'b100
  } jpack_code_e;

  // packet kind, picks which permission applies
  typedef enum logic [1:0] {
    PK_ADDR   = 2'd0,
    PK_DATA_4 = 2'd1,
    PK_DATA_5 = 2'd2
  } pkt_kind_e;

  typedef struct packed {
    pkt_kind_e            kind;
    logic [PAYLOAD_W-1:0] payload;
  } jbi_req_t;

  // send permissions from the tracker
  typedef struct packed {
    logic ok_addr;
    logic ok_data_4;
    logic ok_data_5;
  } jbi_permit_t;

  // one-cycle fatal pulses
  typedef struct packed {
    logic fatal_4;
    logic fatal_5;
  } jbi_err_t;

endpackage

// ==== jbi_req_fifo.sv ====
module jbi_req_fifo import jbi_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  jbi_req_t in_req,
  output logic     out_valid,
  input  logic     out_ready,
  output jbi_req_t out_req
);

  // storage, no reset needed on payload
  jbi_req_t mem [REQ_FIFO_DEPTH];

  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;

  logic push;
  logic pop;

  // full when every slot holds a request
  assign in_ready  = (count != FIFO_CNT_W'(REQ_FIFO_DEPTH));
  // head is visible the cycle after it was written
  assign out_valid = (count != '0);
  assign out_req   = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // pointers and occupancy
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        // wrap at the last slot
        wr_ptr <= (wr_ptr == FIFO_PTR_W'(REQ_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == FIFO_PTR_W'(REQ_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop keeps the count
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // write port
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_req;
    end
  end

endmodule

// ==== jbi_status_log.sv ====
module jbi_status_log import jbi_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  jbi_err_t              err,
  input  logic                  aok_off_any,
  input  logic                  dok_off_any,
  input  logic [1:0]            err_clr,
  output logic [1:0]            fatal_err,
  output logic [PERF_CNT_W-1:0] perf_aok_off_cnt,
  output logic [PERF_CNT_W-1:0] perf_dok_off_cnt
);

  // bit 0 is port 4, bit 1 is port 5
  logic [1:0] fatal_pulse;

  assign fatal_pulse = {err.fatal_5, err.fatal_4};

  // sticky fatal bits, write one to clear
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fatal_err <= '0;
    end else begin
      // a new pulse beats a clear in the same cycle
      fatal_err <= fatal_pulse | (fatal_err & ~err_clr);
    end
  end

  // off-cycle counters, hold at all ones
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      perf_aok_off_cnt <= '0;
      perf_dok_off_cnt <= '0;
    end else begin
      if (aok_off_any && (perf_aok_off_cnt != '1)) begin
        perf_aok_off_cnt <= perf_aok_off_cnt + 1'b1;
      end
      if (dok_off_any && (perf_dok_off_cnt != '1)) begin
        perf_dok_off_cnt <= perf_dok_off_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/bash
# build and run the testbench with Verilator, pass or fail from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_jbi_flow -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; } \
  || { grep -q "Result: PASSED" sim.log && echo "simulation passed" && exit 0; } \
  || { echo "simulation did not finish"; exit 1; }

// ==== tb_jbi_flow.sv ====
module tb_jbi_flow import jbi_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  logic        clk;
  logic        arst_n;
  logic        in_valid, in_ready, out_valid, out_ready;
  jbi_req_t    in_req, out_req;
  jpack_code_e j_pack0_m1, j_pack1_m1, j_pack4_p1, j_pack5_p1;
  logic [1:0]  err_clr, fatal_err;
  logic [PERF_CNT_W-1:0] perf_aok_off_cnt, perf_dok_off_cnt;
  logic [NUM_AID-1:0]    log_arb_aok, log_arb_dok;

  // bookkeeping
  int error_count, check_count, test_count, tx_count, rx_count;
  logic [15:0] lfsr;
  logic        reqs_done;
  jbi_req_t    sb_q[$];
  // cycle each queued request was accepted in
  int          acc_q[$];
  // model permissions per cycle {data 5, data 4, addr}
  logic [2:0]  perm_q[$];
  int          cyc;
  // current out head already checked
  logic        head_seen;

  // model state, flags and own-code delay line
  logic [3:0]  m_aok_q;
  logic [1:0]  m_dok_q, m_fatal;
  jpack_code_e m_d0_1, m_d0_2, m_d1_1, m_d1_2;
  int          m_cnt4, m_cnt5, m_aok_cnt, m_dok_cnt;

  jbi_flow_top jbi_flow_top_inst (.*);

  always #50 clk = ~clk;

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic get_random(input int nbits, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  // expected off flags {dok5, dok4, aok5, aok4, aok1, aok0} for this cycle
  function automatic logic [5:0] ref_off(input logic [3:0] aq, input logic [1:0] dq,
      input jpack_code_e c0, input jpack_code_e c1, input jpack_code_e c4,
      input jpack_code_e c5);
    jpack_code_e codes [4];
    logic [5:0]  off;
    codes = '{c0, c1, c4, c5};
    for (int i = 0; i < 4; i++) begin
      off[i] = (codes[i] == JP_AOK_OFF) || (aq[i] && codes[i] != JP_AOK_ON);
    end
    for (int i = 0; i < 2; i++) begin
      off[4+i] = (codes[2+i] == JP_DOK_OFF) || (dq[i] && codes[2+i] != JP_DOK_ON);
    end
    return off;
  endfunction

  // gate may hold a request from two cycles after its acceptance
  function automatic logic was_permitted(input pkt_kind_e kind, input int from,
      input int upto);
    for (int c = from + 2; c < upto; c++) begin
      case (kind)
        PK_DATA_4: if (perm_q[c][1]) return 1'b1;
        PK_DATA_5: if (perm_q[c][2]) return 1'b1;
        default:   if (perm_q[c][0]) return 1'b1;
      endcase
    end
    return 1'b0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Result: FAILED");
    $finish;
  endtask

  // checker and reference model, sampled mid-cycle
  always @(negedge clk) begin
    logic [5:0]         off;
    logic [NUM_AID-1:0] exp_aok, exp_dok;
    jbi_req_t           exp_req;
    if (arst_n) begin
      off = ref_off(m_aok_q, m_dok_q, m_d0_2, m_d1_2, j_pack4_p1, j_pack5_p1);
      // one bit per port, ports 2, 3, 6 read on
      exp_aok    = '1;
      exp_aok[0] = !off[0];
      exp_aok[1] = !off[1];
      exp_aok[4] = !off[2];
      exp_aok[5] = !off[3];
      exp_dok    = '1;
      exp_dok[4] = !off[4];
      exp_dok[5] = !off[5];
      check_value("log_arb_aok", 32'(log_arb_aok), 32'(exp_aok));
      check_value("log_arb_dok", 32'(log_arb_dok), 32'(exp_dok));
      check_value("fatal_err", 32'(fatal_err), 32'(m_fatal));
      check_value("perf_aok_off_cnt", 32'(perf_aok_off_cnt), 32'(m_aok_cnt));
      check_value("perf_dok_off_cnt", 32'(perf_dok_off_cnt), 32'(m_dok_cnt));
      perm_q.push_back({!off[5], !off[4], !(|off[3:0])});
      // a new head must have seen its permission while in the gate
      if (out_valid && !head_seen && sb_q.size() != 0) begin
        if (!was_permitted(sb_q[0].kind, acc_q[0], cyc)) begin
          error_count++;
          $display("Request %h passed the gate without permission, at %0t",
                   sb_q[0].payload, $time);
        end
      end
      if (in_valid && in_ready) begin
        sb_q.push_back(in_req);
        acc_q.push_back(cyc);
        tx_count++;
      end
      if (out_valid && out_ready) begin
        rx_count++;
        if (sb_q.size() == 0) begin
          error_count++;
          $display("A request left the DUT that was never sent, at %0t", $time);
        end else begin
          exp_req = sb_q.pop_front();
          void'(acc_q.pop_front());
          check_value("out_req", 32'(out_req), 32'(exp_req));
        end
        head_seen = 1'b0;
      end else if (out_valid) begin
        head_seen = 1'b1;
      end
      // advance the model by one clock
      m_fatal = {m_cnt5 == DOK_FATAL_COUNT, m_cnt4 == DOK_FATAL_COUNT} | (m_fatal & ~err_clr);
      m_cnt4  = (j_pack4_p1 != JP_DOK_ON) ? 0 : (m_cnt4 < 7 ? m_cnt4 + 1 : 7);
      m_cnt5  = (j_pack5_p1 != JP_DOK_ON) ? 0 : (m_cnt5 < 7 ? m_cnt5 + 1 : 7);
      m_aok_cnt += (|off[3:0]) ? 1 : 0;
      m_dok_cnt += (|off[5:4]) ? 1 : 0;
      m_aok_q = off[3:0];
      m_dok_q = off[5:4];
      m_d0_2 = m_d0_1;
      m_d0_1 = j_pack0_m1;
      m_d1_2 = m_d1_1;
      m_d1_1 = j_pack1_m1;
      cyc++;
    end
  end

  task automatic send_req(input pkt_kind_e kind, input logic [15:0] payload);
    int waited;
    @(posedge clk);
    in_valid <= 1'b1;
    in_req   <= '{kind: kind, payload: payload};
    waited = 0;
    @(negedge clk);
    while (!in_ready) begin
      waited++;
      if (waited > 1000) stop_on_timeout("in_ready");
      @(negedge clk);
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  // hold a code on one port for some cycles, then idle
  task automatic drive_code(input int port, input jpack_code_e code, input int cycles);
    @(posedge clk);
    for (int i = 0; i <= cycles; i++) begin
      case (port)
        0:       j_pack0_m1 <= (i < cycles) ? code : JP_IDLE;
        1:       j_pack1_m1 <= (i < cycles) ? code : JP_IDLE;
        4:       j_pack4_p1 <= (i < cycles) ? code : JP_IDLE;
        default: j_pack5_p1 <= (i < cycles) ? code : JP_IDLE;
      endcase
      if (i < cycles) @(posedge clk);
    end
  endtask

  task automatic wait_rx(input int target, input int limit);
    int waited;
    waited = 0;
    while (rx_count < target) begin
      waited++;
      if (waited > limit) stop_on_timeout("an out transfer");
      @(posedge clk);
    end
  endtask

  // nothing may leave while blocked
  task automatic expect_held(input int cycles);
    int start;
    start = rx_count;
    repeat (cycles) @(posedge clk);
    if (rx_count != start) begin
      error_count++;
      $display("A blocked request left the DUT at %0t", $time);
    end
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("test %0d %s finished, errors so far %0d", test_count, name, error_count);
  endtask

  initial begin
    logic [31:0] r;
    clk = 0;
    arst_n = 0;
    in_valid = 0;
    in_req = '0;
    out_ready = 1;
    err_clr = 0;
    j_pack0_m1 = JP_IDLE;
    j_pack1_m1 = JP_IDLE;
    j_pack4_p1 = JP_IDLE;
    j_pack5_p1 = JP_IDLE;
    lfsr = 16'd25225;
    reqs_done = 0;
    cyc = 0;
    head_seen = 0;
    {m_aok_q, m_dok_q, m_fatal} = '0;
    m_d0_1 = JP_IDLE;
    m_d0_2 = JP_IDLE;
    m_d1_1 = JP_IDLE;
    m_d1_2 = JP_IDLE;
    {m_cnt4, m_cnt5, m_aok_cnt, m_dok_cnt} = '0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_value("out_valid", 32'(out_valid), 32'd0);
    check_value("in_ready", 32'(in_ready), 32'd1);
    end_test("reset values");

    drive_code(4, JP_AOK_OFF, 1);
    send_req(PK_DATA_4, 16'h1001);
    wait_rx(1, 20);
    send_req(PK_ADDR, 16'h1002);
    expect_held(10);
    drive_code(4, JP_AOK_ON, 1);
    wait_rx(2, 20);
    end_test("port 4 address off");

    drive_code(5, JP_DOK_OFF, 1);
    send_req(PK_DATA_4, 16'h2001);
    wait_rx(3, 20);
    @(negedge clk);
    check_value("log_arb_dok", 32'(log_arb_dok[5]), 32'd0);
    send_req(PK_DATA_5, 16'h2002);
    expect_held(10);
    drive_code(5, JP_DOK_ON, 1);
    wait_rx(4, 20);
    end_test("port 5 data off");

    drive_code(0, JP_AOK_OFF, 1);
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("log_arb_aok", 32'(log_arb_aok[0]), 32'd0);
    send_req(PK_ADDR, 16'h3001);
    expect_held(10);
    drive_code(0, JP_AOK_ON, 1);
    wait_rx(5, 20);
    end_test("own address off");

    drive_code(4, JP_DOK_ON, 3);
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("fatal_err", 32'(fatal_err[0]), 32'd0);
    drive_code(4, JP_DOK_ON, 4);
    repeat (6) @(posedge clk);
    @(negedge clk);
    check_value("fatal_err", 32'(fatal_err[0]), 32'd1);
    @(posedge clk);
    err_clr <= 2'b01;
    @(posedge clk);
    err_clr <= 2'b00;
    @(negedge clk);
    check_value("fatal_err", 32'(fatal_err[0]), 32'd0);
    end_test("stuck data on");

    fork
      begin
        for (int i = 0; i < 150; i++) begin
          get_random(2, r);
          send_req((r == 0) ? PK_ADDR : ((r == 1) ? PK_DATA_4 : PK_DATA_5), 16'(i * 37 + 5));
        end
        reqs_done = 1;
      end
      while (!reqs_done) begin
        @(posedge clk);
        get_random(1, r);
        out_ready <= r[0];
      end
      while (!reqs_done) begin
        @(posedge clk);
        get_random(3, r);
        j_pack0_m1 <= jpack_code_e'(r[2:0]);
        get_random(3, r);
        j_pack1_m1 <= jpack_code_e'(r[2:0]);
        get_random(3, r);
        j_pack4_p1 <= jpack_code_e'(r[2:0]);
        get_random(3, r);
        j_pack5_p1 <= jpack_code_e'(r[2:0]);
      end
    join
    // reopen every flag so the pipeline drains
    @(posedge clk);
    out_ready  <= 1'b1;
    j_pack0_m1 <= JP_AOK_ON;
    j_pack1_m1 <= JP_AOK_ON;
    j_pack4_p1 <= JP_AOK_ON;
    j_pack5_p1 <= JP_AOK_ON;
    @(posedge clk);
    j_pack0_m1 <= JP_IDLE;
    j_pack1_m1 <= JP_IDLE;
    j_pack4_p1 <= JP_DOK_ON;
    j_pack5_p1 <= JP_DOK_ON;
    @(posedge clk);
    j_pack4_p1 <= JP_IDLE;
    j_pack5_p1 <= JP_IDLE;
    repeat (3) @(posedge clk);
    wait_rx(tx_count, 200);
    // an empty pipeline sends nothing more
    repeat (5) @(posedge clk);
    check_value("rx_count", 32'(rx_count), 32'(tx_count));
    @(negedge clk);
    check_value("out_valid", 32'(out_valid), 32'd0);
    end_test("random traffic");

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
